// File: source/st_glue_pkg.sv
// shared types, slot codes and constants of the st bus glue, imported by all rtl blocks
package st_glue_pkg;

	// word address, bits 23 down to 1 of the 68000 bus
	typedef logic [23:1] bus_addr_t;
	typedef logic [15:0] bus_data_t;

	// slot of the current 8 MHz bus cycle as announced by the mmu
	typedef logic [1:0] bus_slot_t;

	localparam bus_slot_t SLOT_PRE    = 2'd0; // cpu precycle
	localparam bus_slot_t SLOT_CPU    = 2'd1; // cpu, blitter or upload
	localparam bus_slot_t SLOT_VIKING = 2'd2; // hires card video fetch
	localparam bus_slot_t SLOT_IDLE   = 2'd3; // unused

	// ram cycle as generated by the mmu
	typedef struct packed {
		bus_addr_t addr;
		bus_data_t data;
		logic      ras_n; // ras0_n & ras1_n
		logic      we_n;
		logic      uds;
		logic      lds;
	} mmu_bus_t;

	// blitter bus master request
	typedef struct packed {
		bus_addr_t addr;
		bus_data_t data;
		logic      read;
		logic      write;
	} master_req_t;

	// one rom image word from the host
	typedef struct packed {
		bus_addr_t addr;
		bus_data_t data;
	} upload_word_t;

	// what the glue sees of the cpu bus
	typedef struct packed {
		bus_addr_t addr;
		logic      as_n;
	} cpu_probe_t;

	// request to the sdram controller
	typedef struct packed {
		bus_addr_t addr;
		bus_data_t data;
		logic      uds;
		logic      lds;
		logic      oe;
		logic      we;
	} mem_req_t;

	// psg channel levels, unsigned
	typedef struct packed {
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
	} psg_chan_t;

	// two's complement mix for the dac
	typedef struct packed {
		logic [14:0] left;
		logic [14:0] right;
	} audio_mix_t;

	localparam logic [5:0] VIKING_WINDOW       = 6'b110000; // $c00000 window
	localparam int         DEFAULT_VIKING_HITS = 255;

	localparam logic [9:0] PSG_OFFSET = 10'h200; // midpoint of a 10 bit psg sum
	localparam logic [7:0] DMA_OFFSET = 8'h80;   // midpoint of a dma sample

endpackage

// File: source/upload_writer.sv
// host upload port, takes words by four-phase req/ack and writes each one in a cpu slot
`timescale 1ns/1ps

module upload_writer (
	input  logic                      clk_32,
	input  logic                      xsint,
	input  st_glue_pkg::bus_slot_t    bus_slot_i,
	input  logic                      bus_en_i,
	input  logic                      upload_req_i,
	input  st_glue_pkg::upload_word_t upload_word_i,
	output logic                      upload_ack_o,
	output st_glue_pkg::upload_word_t wr_word_o,
	output logic                      wr_pulse_o
);

	import st_glue_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT_SLOT,
		ST_ACK
	} state_t;

	state_t       state_q;
	logic         ack_q;
	logic         pulse_q;
	upload_word_t word_q;

	wire cpu_slot = (bus_slot_i == SLOT_CPU) && bus_en_i;

	// word latch, loaded once per handshake
	always_ff @(posedge clk_32) begin
		if (state_q == ST_IDLE && upload_req_i)
			word_q <= upload_word_i;
	end

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			state_q <= ST_IDLE;
			ack_q   <= 1'b0;
			pulse_q <= 1'b0;
		end else begin
			pulse_q <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (upload_req_i)
						state_q <= ST_WAIT_SLOT;
				end
				ST_WAIT_SLOT: begin
					if (cpu_slot) begin
						pulse_q <= 1'b1; // single write strobe
						state_q <= ST_ACK;
					end
				end
				ST_ACK: begin
					ack_q <= 1'b1; // rises the cycle after the pulse
					if (ack_q && !upload_req_i) begin
						ack_q   <= 1'b0;
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	assign upload_ack_o = ack_q;
	assign wr_word_o    = word_q;
	assign wr_pulse_o   = pulse_q;

endmodule

// File: source/viking_detect.sv
// watches cpu accesses to the hires card window and flags the card as in use
`timescale 1ns/1ps

module viking_detect #(
	parameter int VIKING_HITS = st_glue_pkg::DEFAULT_VIKING_HITS
) (
	input  logic                    clk_32,
	input  logic                    xsint,
	input  logic                    bus_en_i,
	input  st_glue_pkg::cpu_probe_t cpu_i,
	input  logic                    viking_enable_i,
	output logic                    viking_active_o
);

	import st_glue_pkg::*;

	localparam int               CNT_W    = $clog2(VIKING_HITS + 1);
	localparam logic [CNT_W-1:0] HITS_MAX = CNT_W'(VIKING_HITS);

	logic [CNT_W-1:0] hits_q;
	logic             active_q;
	logic             window_hit;

	// a driver hammers the window, a stray probe touches it a few times
	assign window_hit = bus_en_i && !cpu_i.as_n && viking_enable_i &&
		(cpu_i.addr[23:18] == VIKING_WINDOW);

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			hits_q   <= '0;
			active_q <= 1'b0;
		end else begin
			if (window_hit && (hits_q < HITS_MAX))
				hits_q <= hits_q + 1'b1; // saturates at the threshold

			// sticky until reset
			if (hits_q == HITS_MAX)
				active_q <= 1'b1;
		end
	end

	assign viking_active_o = active_q;

endmodule

// File: source/bus_slot_mux.sv
// sdram request multiplexer, picks the bus master per slot and registers the request
`timescale 1ns/1ps

module bus_slot_mux (
	input  logic                      clk_32,
	input  logic                      xsint,
	input  st_glue_pkg::bus_slot_t    bus_slot_i,
	input  st_glue_pkg::mmu_bus_t     mmu_i,
	input  st_glue_pkg::master_req_t  blit_i,
	input  logic                      blit_has_bus_i,
	input  logic                      upload_active_i,
	input  st_glue_pkg::upload_word_t wr_word_i,
	input  logic                      wr_pulse_i,
	input  logic                      viking_active_i,
	input  st_glue_pkg::bus_addr_t    viking_addr_i,
	input  logic                      viking_read_i,
	output st_glue_pkg::mem_req_t     mem_req_o
);

	import st_glue_pkg::*;

	logic     ras_n_d;
	logic     mmu_oe;
	logic     mmu_we;
	mem_req_t nxt;

	bus_addr_t addr_q;
	bus_data_t data_q;
	logic      uds_q;
	logic      lds_q;
	logic      oe_q;
	logic      we_q;

	// mmu cycle starts on the falling edge of ras
	assign mmu_oe = ras_n_d && !mmu_i.ras_n && mmu_i.we_n && (|mmu_i.addr);
	assign mmu_we = ras_n_d && !mmu_i.ras_n && !mmu_i.we_n;

	always_comb begin
		// mmu owns the bus unless a slot says otherwise
		nxt.addr = mmu_i.addr;
		nxt.data = mmu_i.data;
		nxt.uds  = mmu_i.uds;
		nxt.lds  = mmu_i.lds;
		nxt.oe   = mmu_oe;
		nxt.we   = mmu_we;

		case (bus_slot_i)
			SLOT_CPU: begin
				if (upload_active_i) begin
					nxt.addr = wr_word_i.addr;
					nxt.data = wr_word_i.data;
					nxt.uds  = 1'b1;
					nxt.lds  = 1'b1;
					nxt.oe   = 1'b0;
					nxt.we   = wr_pulse_i; // one write per upload word
				end else if (blit_has_bus_i) begin
					nxt.addr = blit_i.addr;
					nxt.data = blit_i.data;
					nxt.uds  = 1'b1;
					nxt.lds  = 1'b1;
					nxt.oe   = blit_i.read;
					nxt.we   = blit_i.write;
				end
			end
			SLOT_VIKING: begin
				if (viking_active_i && viking_read_i) begin
					nxt.addr = viking_addr_i;
					nxt.uds  = 1'b1;
					nxt.lds  = 1'b1;
					nxt.oe   = 1'b1;
					nxt.we   = 1'b0;
				end
			end
			default: ; // precycle and idle stay with the mmu
		endcase
	end

	// payload
	always_ff @(posedge clk_32) begin
		addr_q <= nxt.addr;
		data_q <= nxt.data;
		uds_q  <= nxt.uds;
		lds_q  <= nxt.lds;
	end

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ras_n_d <= 1'b1;
			oe_q    <= 1'b0;
			we_q    <= 1'b0;
		end else begin
			ras_n_d <= mmu_i.ras_n;
			oe_q    <= nxt.oe;
			we_q    <= nxt.we;
		end
	end

	assign mem_req_o = '{addr: addr_q, data: data_q, uds: uds_q, lds: lds_q,
		oe: oe_q, we: we_q};

endmodule

// File: source/audio_mixer.sv
// mixes the psg channels and the dma sound samples into two signed 15 bit sums
`timescale 1ns/1ps

module audio_mixer (
	input  logic                    clk_32,
	input  logic                    xsint,
	input  st_glue_pkg::psg_chan_t  psg_i,
	input  logic [7:0]              dma_left_i,
	input  logic [7:0]              dma_right_i,
	input  logic                    psg_stereo_i,
	output st_glue_pkg::audio_mix_t audio_o
);

	import st_glue_pkg::*;

	logic [9:0]  psg_a;
	logic [9:0]  psg_b;
	logic [9:0]  psg_c;
	logic [9:0]  psg_l;
	logic [9:0]  psg_r;
	logic [14:0] mix_l;
	logic [14:0] mix_r;
	audio_mix_t  mix_q;

	// both sources widened to 15 bits and added, wraps on overflow
	function automatic logic [14:0] mix_chan(input logic [9:0] psg_sum,
		input logic [7:0] dma_smp);
		logic [9:0]  psg_s;
		logic [7:0]  dma_s;
		logic [14:0] psg_w;
		logic [14:0] dma_w;
		psg_s = psg_sum - PSG_OFFSET; // unsigned to two's complement
		dma_s = dma_smp - DMA_OFFSET;
		psg_w = {psg_s[9], psg_s, psg_s[9:6]};
		dma_w = {dma_s[7], dma_s, dma_s[7:2]};
		return psg_w + dma_w;
	endfunction

	assign psg_a = {2'b00, psg_i.a};
	assign psg_b = {2'b00, psg_i.b};
	assign psg_c = {2'b00, psg_i.c};

	// stereo puts a left, c right and b in the middle
	always_comb begin
		if (psg_stereo_i) begin
			psg_l = psg_a + psg_b;
			psg_r = psg_c + psg_b;
		end else begin
			psg_l = psg_a + psg_b + psg_c;
			psg_r = psg_a + psg_b + psg_c;
		end
	end

	assign mix_l = mix_chan(psg_l, dma_left_i);
	assign mix_r = mix_chan(psg_r, dma_right_i);

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			mix_q <= '0;
		end else begin
			mix_q.left  <= mix_l;
			mix_q.right <= mix_r;
		end
	end

	assign audio_o = mix_q;

endmodule

// File: source/st_glue_top.sv
// top of the memory bus glue, connects upload port, card detect, sdram mux and audio mix
`timescale 1ns/1ps

module st_glue_top #(
	parameter int VIKING_HITS = st_glue_pkg::DEFAULT_VIKING_HITS
) (
	input  logic                      clk_32,
	input  logic                      xsint,
	// mmu slot timing
	input  st_glue_pkg::bus_slot_t    bus_slot_i,
	input  logic                      bus_en_i,     // 8 MHz enable
	// bus masters
	input  st_glue_pkg::mmu_bus_t     mmu_i,
	input  st_glue_pkg::master_req_t  blit_i,
	input  logic                      blit_has_bus_i,
	input  st_glue_pkg::bus_addr_t    viking_addr_i,
	input  logic                      viking_read_i,
	// cpu probe for the card window
	input  st_glue_pkg::cpu_probe_t   cpu_i,
	input  logic                      viking_enable_i,
	// host rom upload
	input  logic                      upload_active_i,
	input  logic                      upload_req_i,
	input  st_glue_pkg::upload_word_t upload_word_i,
	output logic                      upload_ack_o,
	// audio sources
	input  st_glue_pkg::psg_chan_t    psg_i,
	input  logic [7:0]                dma_left_i,
	input  logic [7:0]                dma_right_i,
	input  logic                      psg_stereo_i,
	// results
	output st_glue_pkg::mem_req_t     mem_req_o,
	output logic                      viking_active_o,
	output st_glue_pkg::audio_mix_t   audio_o
);

	import st_glue_pkg::*;

	upload_word_t wr_word;  // latched upload word
	logic         wr_pulse; // one clock per word

	upload_writer upload_writer_i (
		.clk_32        ( clk_32        ),
		.xsint         ( xsint         ),
		.bus_slot_i    ( bus_slot_i    ),
		.bus_en_i      ( bus_en_i      ),
		.upload_req_i  ( upload_req_i  ),
		.upload_word_i ( upload_word_i ),
		.upload_ack_o  ( upload_ack_o  ),
		.wr_word_o     ( wr_word       ),
		.wr_pulse_o    ( wr_pulse      )
	);

	viking_detect #(.VIKING_HITS(VIKING_HITS)) viking_detect_i (
		.clk_32          ( clk_32          ),
		.xsint           ( xsint           ),
		.bus_en_i        ( bus_en_i        ),
		.cpu_i           ( cpu_i           ),
		.viking_enable_i ( viking_enable_i ),
		.viking_active_o ( viking_active_o )
	);

	bus_slot_mux bus_slot_mux_i (
		.clk_32          ( clk_32          ),
		.xsint           ( xsint           ),
		.bus_slot_i      ( bus_slot_i      ),
		.mmu_i           ( mmu_i           ),
		.blit_i          ( blit_i          ),
		.blit_has_bus_i  ( blit_has_bus_i  ),
		.upload_active_i ( upload_active_i ),
		.wr_word_i       ( wr_word         ),
		.wr_pulse_i      ( wr_pulse        ),
		.viking_active_i ( viking_active_o ), // video fetch only once the card is live
		.viking_addr_i   ( viking_addr_i   ),
		.viking_read_i   ( viking_read_i   ),
		.mem_req_o       ( mem_req_o       )
	);

	audio_mixer audio_mixer_i (
		.clk_32       ( clk_32       ),
		.xsint        ( xsint        ),
		.psg_i        ( psg_i        ),
		.dma_left_i   ( dma_left_i   ),
		.dma_right_i  ( dma_right_i  ),
		.psg_stereo_i ( psg_stereo_i ),
		.audio_o      ( audio_o      )
	);

endmodule

// File: test/st_glue_tb.sv
// testbench that replays the golden vectors through the st bus glue and checks each block
`timescale 1ns/1ps

module st_glue_tb;

	import st_glue_pkg::*;

	localparam int HITS    = 8;
	localparam int TIMEOUT = 64; // clocks per wait

	typedef struct packed {
		logic        stereo;
		psg_chan_t   psg;
		logic [7:0]  dma_l;
		logic [7:0]  dma_r;
		logic [14:0] left;
		logic [14:0] right;
	} audio_vec_t;

	logic         clk_32;
	logic         xsint;
	bus_slot_t    bus_slot_i;
	logic         bus_en_i;
	mmu_bus_t     mmu_i;
	master_req_t  blit_i;
	logic         blit_has_bus_i;
	bus_addr_t    viking_addr_i;
	logic         viking_read_i;
	cpu_probe_t   cpu_i;
	logic         viking_enable_i;
	logic         upload_active_i;
	logic         upload_req_i;
	upload_word_t upload_word_i;
	logic         upload_ack_o;
	psg_chan_t    psg_i;
	logic [7:0]   dma_left_i;
	logic [7:0]   dma_right_i;
	logic         psg_stereo_i;
	mem_req_t     mem_req_o;
	logic         viking_active_o;
	audio_mix_t   audio_o;

	audio_vec_t   audio_q[$];
	upload_word_t upload_q[$];
	int           gold_hits;
	int           seed;
	int           cyc;
	int           errors;
	int           tests;
	logic         slot_cycling; // mmu slot rotation on

	st_glue_top #(.VIKING_HITS(HITS)) st_glue_top_i (.*);

	initial begin
		clk_32 = 1'b0;
		forever #5 clk_32 = ~clk_32;
	end

	// one clock that ends 1 ns after the rising edge
	task automatic tick();
		@(posedge clk_32);
		#1;
		cyc++;
		if (slot_cycling) begin
			bus_slot_i = bus_slot_t'(cyc[3:2]); // four clocks per bus cycle
			bus_en_i   = (cyc[1:0] == 2'd0);
		end
	endtask

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("error %t %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("%t %s", $time, what);
	endtask

	task automatic report_test(input string name, input int err0);
		tests++;
		if (errors == err0)
			$display("test %s ok", name);
		else
			$display("test %s failed, %0d errors", name, errors - err0);
	endtask

	task automatic load_golden(output bit ok);
		int          fd;
		int          n;
		string       line;
		logic [31:0] v [8];
		ok = 1'b0;
		fd = $fopen("test/st_glue_golden.txt", "r");
		if (fd == 0)
			return;
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line[0] == "#")
				continue;
			if (line[0] == "A") begin
				n = $sscanf(line, "A %h %h %h %h %h %h %h %h", v[0], v[1], v[2], v[3],
					v[4], v[5], v[6], v[7]);
				audio_q.push_back('{stereo: v[0][0], psg: {v[1][7:0], v[2][7:0], v[3][7:0]},
					dma_l: v[4][7:0], dma_r: v[5][7:0], left: v[6][14:0], right: v[7][14:0]});
			end else if (line[0] == "U") begin
				n = $sscanf(line, "U %h %h", v[0], v[1]);
				upload_q.push_back('{addr: v[0][22:0], data: v[1][15:0]});
			end else if (line[0] == "H") begin
				n = $sscanf(line, "H %h", v[0]);
				gold_hits = v[0];
			end
		end
		$fclose(fd);
		ok = (audio_q.size() > 0) && (upload_q.size() > 0) && (gold_hits > 0);
	endtask

	task automatic replay_audio();
		foreach (audio_q[i]) begin
			psg_stereo_i = audio_q[i].stereo;
			psg_i        = audio_q[i].psg;
			dma_left_i   = audio_q[i].dma_l;
			dma_right_i  = audio_q[i].dma_r;
			tick();
			compare("audio_o.left", audio_q[i].left, audio_o.left);
			compare("audio_o.right", audio_q[i].right, audio_o.right);
		end
	endtask

	// counts sdram writes and checks the one that carries the word
	task automatic watch_write(input upload_word_t w, inout int writes);
		if (mem_req_o.we) begin
			writes++;
			compare("mem_req_o.addr", w.addr, mem_req_o.addr);
			compare("mem_req_o.data", w.data, mem_req_o.data);
			compare("mem_req_o.uds", 1, mem_req_o.uds);
			compare("mem_req_o.lds", 1, mem_req_o.lds);
			compare("mem_req_o.oe", 0, mem_req_o.oe);
		end
	endtask

	task automatic replay_uploads();
		int writes;
		int n;
		upload_active_i = 1'b1;
		slot_cycling    = 1'b1;
		foreach (upload_q[i]) begin
			writes        = 0;
			n             = 0;
			upload_word_i = upload_q[i];
			upload_req_i  = 1'b1;
			while (!upload_ack_o && n < TIMEOUT) begin
				tick();
				watch_write(upload_q[i], writes);
				n++;
			end
			if (!upload_ack_o)
				report_failure("upload_ack_o did not rise for an upload word");
			upload_req_i = 1'b0;
			n            = 0;
			while (upload_ack_o && n < TIMEOUT) begin
				tick();
				watch_write(upload_q[i], writes);
				n++;
			end
			if (upload_ack_o)
				report_failure("upload_ack_o stayed high after req was dropped");
			compare("upload_ack_o fall delay", 1, n);
			repeat (16) begin // a repeated write would show within a full slot rotation
				tick();
				watch_write(upload_q[i], writes);
			end
			compare("mem_req_o.we pulses", 1, writes);
		end
		upload_active_i = 1'b0;
		slot_cycling    = 1'b0;
		bus_slot_i      = SLOT_PRE;
		bus_en_i        = 1'b0;
	endtask

	// one mmu ram cycle where ras falls after a high clock
	task automatic mmu_cycle(input bus_addr_t addr, input logic we_n, input logic exp_oe,
		input logic exp_we);
		mmu_i.addr  = addr;
		mmu_i.we_n  = we_n;
		mmu_i.ras_n = 1'b1;
		tick();
		mmu_i.ras_n = 1'b0;
		for (int i = 0; i < 4; i++) begin
			tick();
			compare("mem_req_o.oe", (i == 0) ? exp_oe : 1'b0, mem_req_o.oe);
			compare("mem_req_o.we", (i == 0) ? exp_we : 1'b0, mem_req_o.we);
		end
		compare("mem_req_o.addr", addr, mem_req_o.addr);
		mmu_i.ras_n = 1'b1;
	endtask

	task automatic exercise_bus();
		bus_slot_t others [3] = '{SLOT_PRE, SLOT_VIKING, SLOT_IDLE};
		mmu_i.addr     = bus_addr_t'($random(seed)) | 23'd1; // never zero
		blit_i         = '{addr: bus_addr_t'($random(seed)), data: 16'hb117, read: 1'b1,
			write: 1'b0};
		blit_has_bus_i = 1'b1;
		bus_slot_i     = SLOT_CPU;
		tick();
		compare("mem_req_o.addr", blit_i.addr, mem_req_o.addr);
		compare("mem_req_o.data", blit_i.data, mem_req_o.data);
		compare("mem_req_o.uds", 1, mem_req_o.uds);
		compare("mem_req_o.lds", 1, mem_req_o.lds);
		compare("mem_req_o.oe", 1, mem_req_o.oe);
		compare("mem_req_o.we", 0, mem_req_o.we);
		blit_i.read  = 1'b0;
		blit_i.write = 1'b1;
		tick();
		compare("mem_req_o.oe", 0, mem_req_o.oe);
		compare("mem_req_o.we", 1, mem_req_o.we);
		foreach (others[i]) begin
			bus_slot_i = others[i];
			tick();
			compare("mem_req_o.addr", mmu_i.addr, mem_req_o.addr);
			compare("mem_req_o.data", mmu_i.data, mem_req_o.data);
			compare("mem_req_o.uds", mmu_i.uds, mem_req_o.uds);
			compare("mem_req_o.lds", mmu_i.lds, mem_req_o.lds);
		end
		blit_has_bus_i = 1'b0;
		bus_slot_i     = SLOT_PRE;
		mmu_cycle(bus_addr_t'($random(seed)) | 23'd1, 1'b1, 1'b1, 1'b0);
		mmu_cycle('0, 1'b1, 1'b0, 1'b0); // address zero reads get no oe
		mmu_cycle(bus_addr_t'($random(seed)), 1'b0, 1'b0, 1'b1);
	endtask

	task automatic window_access(input logic en, input logic [5:0] top);
		cpu_i.addr      = {top, 17'($random(seed))};
		cpu_i.as_n      = 1'b0;
		viking_enable_i = en;
		bus_en_i        = 1'b1;
		tick();
		cpu_i.as_n = 1'b1;
		bus_en_i   = 1'b0;
	endtask

	task automatic detect_card();
		int   hits;
		logic seen;
		window_access(1'b0, 6'b110000); // card disabled
		window_access(1'b1, 6'b110001); // outside the window
		hits = 0;
		seen = 1'b0;
		while (!seen && hits < 4 * gold_hits) begin
			window_access(1'b1, 6'b110000);
			hits++;
			for (int n = 0; n < 3 && !seen; n++) begin
				tick();
				seen = viking_active_o;
			end
		end
		if (!seen)
			report_failure("viking_active_o never rose during window accesses");
		else
			compare("viking_active_o hit count", gold_hits, hits);
		viking_addr_i = bus_addr_t'($random(seed));
		viking_read_i = 1'b1;
		bus_slot_i    = SLOT_VIKING;
		tick();
		compare("mem_req_o.addr", viking_addr_i, mem_req_o.addr);
		compare("mem_req_o.oe", 1, mem_req_o.oe);
		compare("mem_req_o.we", 0, mem_req_o.we);
		viking_read_i = 1'b0;
		bus_slot_i    = SLOT_PRE;
	endtask

	initial begin
		bit ok;
		int err0;
		$timeformat(-9, 0, " ns", 0);
		seed            = 83251;
		errors          = 0;
		tests           = 0;
		cyc             = 0;
		slot_cycling    = 1'b0;
		xsint           = 1'b0;
		bus_slot_i      = SLOT_PRE;
		bus_en_i        = 1'b0;
		mmu_i           = '{addr: '0, data: 16'h3c3c, ras_n: 1'b1, we_n: 1'b1,
			uds: 1'b0, lds: 1'b0};
		blit_i          = '0;
		blit_has_bus_i  = 1'b0;
		viking_addr_i   = '0;
		viking_read_i   = 1'b0;
		cpu_i           = '{addr: '0, as_n: 1'b1};
		viking_enable_i = 1'b0;
		upload_active_i = 1'b0;
		upload_req_i    = 1'b0;
		upload_word_i   = '0;
		psg_i           = '0;
		dma_left_i      = 8'h80;
		dma_right_i     = 8'h80;
		psg_stereo_i    = 1'b0;
		repeat (2) @(posedge clk_32);
		#1;
		xsint = 1'b1;
		err0  = errors;
		compare("viking_active_o", 0, viking_active_o);
		compare("upload_ack_o", 0, upload_ack_o);
		compare("mem_req_o.oe", 0, mem_req_o.oe);
		compare("mem_req_o.we", 0, mem_req_o.we);
		compare("audio_o", 0, audio_o);
		report_test("reset", err0);
		load_golden(ok);
		if (!ok) begin
			report_failure("golden file missing or incomplete");
		end else begin
			err0 = errors;
			replay_audio();
			report_test("audio mix", err0);
			err0 = errors;
			replay_uploads();
			report_test("upload", err0);
			err0 = errors;
			exercise_bus();
			report_test("blitter and mmu", err0);
			err0 = errors;
			detect_card();
			report_test("viking detect", err0);
		end
		$display("%0d tests, %0d errors", tests, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: test/st_glue_golden.txt
# A stereo a b c dma_l dma_r left right : audio vector and expected 15 bit sums
# U addr data : upload word, H n : window accesses that raise the card flag, all hex
A 1 00 00 00 80 80 6008 6008
A 1 80 80 80 80 80 700c 700c
A 1 ff ff 00 80 80 7fef 6ffb
A 0 ff ff ff 80 80 0fd3 0fd3
A 0 ff ff ff ff 00 2fb2 6ff3
A 1 00 00 00 00 ff 4028 7fe7
A 0 10 20 30 90 70 6a0d 6245
A 1 10 20 30 90 70 670c 6145
A 1 c0 c0 40 c0 40 081e 603c
A 0 c0 c0 40 c0 40 0c1f 6c3f
A 0 ff ff 02 80 81 0000 0040
A 1 01 ff 02 7f 80 700b 701c
U 070000 1234
U 070001 abcd
U 3ffffe 55aa
U 000100 0ff0
H 8

// File: project.f
source/st_glue_pkg.sv
source/upload_writer.sv
source/viking_detect.sv
source/bus_slot_mux.sv
source/audio_mixer.sv
source/st_glue_top.sv
test/st_glue_tb.sv

// File: Makefile
SIM = obj_dir/Vst_glue_tb

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'sim passed'

$(SIM): project.f $(wildcard source/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing -Wno-fatal --top-module st_glue_tb -f project.f

clean:
	rm -rf obj_dir
